// ==== hw/rv32i_pkg.sv ====
`default_nettype none

package rv32i_pkg;

  // Major opcodes of the supported subset
  typedef enum logic [6:0] {
    opc_lui    = 7'b0110111,
    opc_auipc  = 7'b0010111,
    opc_jal    = 7'b1101111,
    opc_jalr   = 7'b1100111,
    opc_branch = 7'b1100011,
    opc_load   = 7'b0000011,
    opc_store  = 7'b0100011,
    opc_op_imm = 7'b0010011,
    opc_op     = 7'b0110011
  } opcode_t;

  typedef enum logic [2:0] {
    br_beq  = 3'b000,
    br_bne  = 3'b001,
    br_blt  = 3'b100,
    br_bge  = 3'b101,
    br_bltu = 3'b110,
    br_bgeu = 3'b111
  } branch_f3_t;

  typedef enum logic [2:0] {
    ld_lb  = 3'b000,
    ld_lh  = 3'b001,
    ld_lw  = 3'b010,
    ld_lbu = 3'b100,
    ld_lhu = 3'b101
  } load_f3_t;

  typedef enum logic [2:0] {
    st_sb = 3'b000,
    st_sh = 3'b001,
    st_sw = 3'b010
  } store_f3_t;

  // Register and immediate ALU operations
  typedef enum logic [2:0] {
    f3_add  = 3'b000,
    f3_sll  = 3'b001,
    f3_slt  = 3'b010,
    f3_sltu = 3'b011,
    f3_xor  = 3'b100,
    f3_sr   = 3'b101,
    f3_or   = 3'b110,
    f3_and  = 3'b111
  } arith_f3_t;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    opcode_t    opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    opcode_t     opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_hi;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    opcode_t    opcode;
  } s_fmt_t;

  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic       imm11;
    opcode_t    opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm;
    logic [4:0]  rd;
    opcode_t     opcode;
  } u_fmt_t;

  typedef struct packed {
    logic       imm20;
    logic [9:0] imm10_1;
    logic       imm11;
    logic [7:0] imm19_12;
    logic [4:0] rd;
    opcode_t    opcode;
  } j_fmt_t;

  // One fetched word seen in every format
  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
    s_fmt_t s_fmt;
    b_fmt_t b_fmt;
    u_fmt_t u_fmt;
    j_fmt_t j_fmt;
  } instr_u;

endpackage

`default_nettype wire

// ==== hw/pipe_pkg.sv ====
`default_nettype none

package pipe_pkg;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and,
    alu_pass_b
  } alu_op_t;

  typedef enum logic {
    a_rs1,
    a_pc
  } a_sel_t;

  typedef enum logic [2:0] {
    b_rs2,
    b_i_imm,
    b_s_imm,
    b_b_imm,
    b_u_imm,
    b_j_imm
  } b_sel_t;

  typedef enum logic [1:0] {
    wb_alu,
    wb_load,
    wb_pc4
  } wb_sel_t;

  // All-zero word is a bubble
  typedef struct packed {
    a_sel_t  a_sel;
    b_sel_t  b_sel;
    alu_op_t alu_op;
    logic    cmp_imm;
    logic    mem_read;
    logic    mem_write;
    logic    reg_write;
    wb_sel_t wb_sel;
    logic    is_branch;
    logic    is_jump;
  } ctrl_word_t;

  typedef struct packed {
    logic [31:0]       pc;
    rv32i_pkg::instr_u instr;
  } id_stage_t;

  typedef struct packed {
    logic [31:0]       pc;
    rv32i_pkg::instr_u instr;
    ctrl_word_t        ctrl;
    logic [31:0]       rs1;
    logic [31:0]       rs2;
  } ex_stage_t;

  // rs2 carries the store data into MEM
  typedef struct packed {
    logic [31:0]       pc;
    rv32i_pkg::instr_u instr;
    ctrl_word_t        ctrl;
    logic [31:0]       alu;
    logic [31:0]       rs2;
    logic              taken;
  } mem_stage_t;

  typedef struct packed {
    mem_stage_t  ms;
    logic [31:0] load_word;
  } wb_stage_t;

  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  mbe;
    logic        read;
    logic        write;
  } dmem_req_t;

endpackage

`default_nettype wire

// ==== hw/ctrl_rom.sv ====
`timescale 1ns/1ps
`default_nettype none

module ctrl_rom (
  input  wire rv32i_pkg::opcode_t opcode,
  input  wire logic [2:0]         funct3,
  input  wire logic [6:0]         funct7,
  output pipe_pkg::ctrl_word_t    ctrl
);

  function automatic pipe_pkg::alu_op_t alu_decode(logic [2:0] f3, logic alt);
    pipe_pkg::alu_op_t op;
    case (rv32i_pkg::arith_f3_t'(f3))
      rv32i_pkg::f3_add:  op = alt ? pipe_pkg::alu_sub : pipe_pkg::alu_add;
      rv32i_pkg::f3_sll:  op = pipe_pkg::alu_sll;
      rv32i_pkg::f3_slt:  op = pipe_pkg::alu_slt;
      rv32i_pkg::f3_sltu: op = pipe_pkg::alu_sltu;
      rv32i_pkg::f3_xor:  op = pipe_pkg::alu_xor;
      rv32i_pkg::f3_sr:   op = alt ? pipe_pkg::alu_sra : pipe_pkg::alu_srl;
      rv32i_pkg::f3_or:   op = pipe_pkg::alu_or;
      default:            op = pipe_pkg::alu_and;
    endcase
    return op;
  endfunction

  always_comb begin
    ctrl = '0;
    case (opcode)
      rv32i_pkg::opc_lui: begin
        ctrl.b_sel     = pipe_pkg::b_u_imm;
        ctrl.alu_op    = pipe_pkg::alu_pass_b;
        ctrl.reg_write = 1'b1;
      end
      rv32i_pkg::opc_auipc: begin
        ctrl.a_sel     = pipe_pkg::a_pc;
        ctrl.b_sel     = pipe_pkg::b_u_imm;
        ctrl.reg_write = 1'b1;
      end
      rv32i_pkg::opc_jal: begin
        ctrl.a_sel     = pipe_pkg::a_pc;
        ctrl.b_sel     = pipe_pkg::b_j_imm;
        ctrl.reg_write = 1'b1;
        ctrl.wb_sel    = pipe_pkg::wb_pc4;
        ctrl.is_jump   = 1'b1;
      end
      rv32i_pkg::opc_jalr: begin
        ctrl.b_sel     = pipe_pkg::b_i_imm;
        ctrl.reg_write = 1'b1;
        ctrl.wb_sel    = pipe_pkg::wb_pc4;
        ctrl.is_jump   = 1'b1;
      end
      rv32i_pkg::opc_branch: begin
        // ALU forms the target, comparator decides
        ctrl.a_sel     = pipe_pkg::a_pc;
        ctrl.b_sel     = pipe_pkg::b_b_imm;
        ctrl.is_branch = 1'b1;
      end
      rv32i_pkg::opc_load: begin
        ctrl.b_sel     = pipe_pkg::b_i_imm;
        ctrl.mem_read  = 1'b1;
        ctrl.reg_write = 1'b1;
        ctrl.wb_sel    = pipe_pkg::wb_load;
      end
      rv32i_pkg::opc_store: begin
        ctrl.b_sel     = pipe_pkg::b_s_imm;
        ctrl.mem_write = 1'b1;
      end
      rv32i_pkg::opc_op_imm: begin
        // funct7 only qualifies the right shift here
        ctrl.b_sel     = pipe_pkg::b_i_imm;
        ctrl.alu_op    = alu_decode(funct3, funct7[5] && funct3 == 3'b101);
        ctrl.cmp_imm   = 1'b1;
        ctrl.reg_write = 1'b1;
      end
      rv32i_pkg::opc_op: begin
        ctrl.alu_op    = alu_decode(funct3, funct7[5]);
        ctrl.reg_write = 1'b1;
      end
      default: ctrl = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== hw/regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module regfile (
  input  wire logic        clk,
  input  wire logic        arst_n,
  input  wire logic        we,
  input  wire logic [4:0]  rd_addr,
  input  wire logic [4:0]  rs1_addr,
  input  wire logic [4:0]  rs2_addr,
  input  wire logic [31:0] rd_data,
  output logic      [31:0] rs1_data,
  output logic      [31:0] rs2_data
);

  logic [31:0] regs [32];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd_addr != 5'd0) begin
      regs[rd_addr] <= rd_data;
    end
  end

  // Write-through so WB and ID can share a cycle
  always_comb begin
    if (rs1_addr == 5'd0) rs1_data = '0;
    else if (we && rd_addr == rs1_addr) rs1_data = rd_data;
    else rs1_data = regs[rs1_addr];

    if (rs2_addr == 5'd0) rs2_data = '0;
    else if (we && rd_addr == rs2_addr) rs2_data = rd_data;
    else rs2_data = regs[rs2_addr];
  end

endmodule

`default_nettype wire

// ==== hw/alu_cmp.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_cmp (
  input  wire pipe_pkg::alu_op_t     alu_op,
  input  wire logic [31:0]           a,
  input  wire logic [31:0]           b,
  input  wire rv32i_pkg::branch_f3_t cmp_op,
  input  wire logic [31:0]           cmp_a,
  input  wire logic [31:0]           cmp_b,
  output logic      [31:0]           result,
  output logic                       cmp_true
);

  always_comb begin
    case (cmp_op)
      rv32i_pkg::br_beq:  cmp_true = cmp_a == cmp_b;
      rv32i_pkg::br_bne:  cmp_true = cmp_a != cmp_b;
      rv32i_pkg::br_blt:  cmp_true = $signed(cmp_a) < $signed(cmp_b);
      rv32i_pkg::br_bge:  cmp_true = $signed(cmp_a) >= $signed(cmp_b);
      rv32i_pkg::br_bltu: cmp_true = cmp_a < cmp_b;
      rv32i_pkg::br_bgeu: cmp_true = cmp_a >= cmp_b;
      default:            cmp_true = 1'b0;
    endcase
  end

  always_comb begin
    case (alu_op)
      pipe_pkg::alu_add:    result = a + b;
      pipe_pkg::alu_sub:    result = a - b;
      pipe_pkg::alu_sll:    result = a << b[4:0];
      pipe_pkg::alu_srl:    result = a >> b[4:0];
      pipe_pkg::alu_sra:    result = $unsigned($signed(a) >>> b[4:0]);
      pipe_pkg::alu_xor:    result = a ^ b;
      pipe_pkg::alu_or:     result = a | b;
      pipe_pkg::alu_and:    result = a & b;
      // Set-less-than reuses the comparator
      pipe_pkg::alu_slt,
      pipe_pkg::alu_sltu:   result = {31'd0, cmp_true};
      pipe_pkg::alu_pass_b: result = b;
      default:              result = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== hw/dmem_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module dmem_fsm (
  input  wire logic               clk,
  input  wire logic               arst_n,
  input  wire pipe_pkg::dmem_req_t mem_req,
  output pipe_pkg::dmem_req_t     dcache_req,
  input  wire logic               dcache_resp,
  input  wire logic [31:0]        dcache_rdata,
  output logic                    stall,
  output logic      [31:0]        load_data
);

  typedef enum logic [1:0] {
    st_idle,
    st_wait,
    st_done
  } state_t;

  state_t      state_q;
  state_t      state_d;
  logic [31:0] load_q;
  logic        access;

  assign access = mem_req.read || mem_req.write;

  always_comb begin
    state_d = state_q;
    case (state_q)
      st_idle: if (access) state_d = st_wait;
      st_wait: if (dcache_resp) state_d = st_done;
      default: state_d = st_idle;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) state_q <= st_idle;
    else state_q <= state_d;
  end

  always_ff @(posedge clk) begin
    if (state_q == st_wait && dcache_resp) load_q <= dcache_rdata;
  end

  // Request is only live while waiting, done lets the access retire
  always_comb begin
    dcache_req       = mem_req;
    dcache_req.read  = mem_req.read && state_q == st_wait;
    dcache_req.write = mem_req.write && state_q == st_wait;
  end

  assign stall     = (state_q == st_idle && access) || state_q == st_wait;
  assign load_data = load_q;

endmodule

`default_nettype wire

// ==== hw/datapath.sv ====
`timescale 1ns/1ps
`default_nettype none

module datapath #(
  parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
  input  wire logic        clk,
  input  wire logic        arst_n,
  output logic      [31:0] icache_addr,
  input  wire logic [31:0] icache_rdata,
  output pipe_pkg::dmem_req_t mem_req,
  input  wire logic        stall,
  input  wire logic [31:0] load_data
);

  logic [31:0]            pc_q;
  logic [31:0]            next_pc;
  logic                   flush;
  pipe_pkg::id_stage_t    id_q;
  pipe_pkg::ex_stage_t    ex_q;
  pipe_pkg::mem_stage_t   mem_q;
  pipe_pkg::wb_stage_t    wb_q;

  pipe_pkg::ctrl_word_t   id_ctrl;
  logic [31:0]            rs1_val;
  logic [31:0]            rs2_val;

  logic [31:0]            imm_i;
  logic [31:0]            imm_s;
  logic [31:0]            imm_b;
  logic [31:0]            imm_u;
  logic [31:0]            imm_j;
  logic [31:0]            alu_a;
  logic [31:0]            alu_b;
  logic [31:0]            cmp_b;
  rv32i_pkg::branch_f3_t  cmp_op;
  logic [31:0]            alu_result;
  logic                   cmp_true;
  logic                   ex_taken;

  logic [1:0]             wb_off;
  logic [7:0]             wb_byte;
  logic [15:0]            wb_half;
  logic [31:0]            load_ext;
  logic [31:0]            wb_data;

  // IF
  assign icache_addr = {pc_q[31:2], 2'b00};
  assign flush       = mem_q.taken;
  assign next_pc     = flush ? {mem_q.alu[31:1], 1'b0} : pc_q + 32'd4;

  // ID
  ctrl_rom ctrl_rom_i (
    .opcode (id_q.instr.r_fmt.opcode),
    .funct3 (id_q.instr.r_fmt.funct3),
    .funct7 (id_q.instr.r_fmt.funct7),
    .ctrl   (id_ctrl)
  );

  regfile regfile_i (
    .clk      (clk),
    .arst_n   (arst_n),
    .we       (wb_q.ms.ctrl.reg_write),
    .rd_addr  (wb_q.ms.instr.r_fmt.rd),
    .rs1_addr (id_q.instr.r_fmt.rs1),
    .rs2_addr (id_q.instr.r_fmt.rs2),
    .rd_data  (wb_data),
    .rs1_data (rs1_val),
    .rs2_data (rs2_val)
  );

  // EX immediates, one view of the union per format
  assign imm_i = {{20{ex_q.instr.i_fmt.imm[11]}}, ex_q.instr.i_fmt.imm};
  assign imm_s = {{20{ex_q.instr.s_fmt.imm_hi[6]}}, ex_q.instr.s_fmt.imm_hi,
                  ex_q.instr.s_fmt.imm_lo};
  assign imm_b = {{19{ex_q.instr.b_fmt.imm12}}, ex_q.instr.b_fmt.imm12,
                  ex_q.instr.b_fmt.imm11, ex_q.instr.b_fmt.imm10_5,
                  ex_q.instr.b_fmt.imm4_1, 1'b0};
  assign imm_u = {ex_q.instr.u_fmt.imm, 12'h000};
  assign imm_j = {{11{ex_q.instr.j_fmt.imm20}}, ex_q.instr.j_fmt.imm20,
                  ex_q.instr.j_fmt.imm19_12, ex_q.instr.j_fmt.imm11,
                  ex_q.instr.j_fmt.imm10_1, 1'b0};

  always_comb begin
    alu_a = (ex_q.ctrl.a_sel == pipe_pkg::a_pc) ? ex_q.pc : ex_q.rs1;
    case (ex_q.ctrl.b_sel)
      pipe_pkg::b_i_imm: alu_b = imm_i;
      pipe_pkg::b_s_imm: alu_b = imm_s;
      pipe_pkg::b_b_imm: alu_b = imm_b;
      pipe_pkg::b_u_imm: alu_b = imm_u;
      pipe_pkg::b_j_imm: alu_b = imm_j;
      default:           alu_b = ex_q.rs2;
    endcase
    cmp_b = ex_q.ctrl.cmp_imm ? imm_i : ex_q.rs2;
    // slt and sltu borrow the signed and unsigned less-than compare
    if (ex_q.ctrl.is_branch) cmp_op = rv32i_pkg::branch_f3_t'(ex_q.instr.b_fmt.funct3);
    else if (ex_q.ctrl.alu_op == pipe_pkg::alu_sltu) cmp_op = rv32i_pkg::br_bltu;
    else cmp_op = rv32i_pkg::br_blt;
  end

  alu_cmp alu_cmp_i (
    .alu_op   (ex_q.ctrl.alu_op),
    .a        (alu_a),
    .b        (alu_b),
    .cmp_op   (cmp_op),
    .cmp_a    (ex_q.rs1),
    .cmp_b    (cmp_b),
    .result   (alu_result),
    .cmp_true (cmp_true)
  );

  assign ex_taken = ex_q.ctrl.is_jump || (ex_q.ctrl.is_branch && cmp_true);

  // MEM store alignment
  always_comb begin
    mem_req.addr  = {mem_q.alu[31:2], 2'b00};
    mem_req.read  = mem_q.ctrl.mem_read;
    mem_req.write = mem_q.ctrl.mem_write;
    case (rv32i_pkg::store_f3_t'(mem_q.instr.s_fmt.funct3))
      rv32i_pkg::st_sb: begin
        mem_req.wdata = mem_q.rs2 << {mem_q.alu[1:0], 3'b000};
        mem_req.mbe   = 4'b0001 << mem_q.alu[1:0];
      end
      rv32i_pkg::st_sh: begin
        mem_req.wdata = mem_q.rs2 << {mem_q.alu[1:0], 3'b000};
        mem_req.mbe   = 4'b0011 << mem_q.alu[1:0];
      end
      rv32i_pkg::st_sw: begin
        mem_req.wdata = mem_q.rs2;
        mem_req.mbe   = 4'b1111;
      end
      default: begin
        mem_req.wdata = '0;
        mem_req.mbe   = 4'b0000;
      end
    endcase
  end

  // WB load extension
  always_comb begin
    wb_off  = wb_q.ms.alu[1:0];
    wb_byte = wb_q.load_word[{wb_off, 3'b000} +: 8];
    wb_half = wb_off[1] ? wb_q.load_word[31:16] : wb_q.load_word[15:0];
    case (rv32i_pkg::load_f3_t'(wb_q.ms.instr.i_fmt.funct3))
      rv32i_pkg::ld_lb:  load_ext = {{24{wb_byte[7]}}, wb_byte};
      rv32i_pkg::ld_lbu: load_ext = {24'd0, wb_byte};
      rv32i_pkg::ld_lh:  load_ext = {{16{wb_half[15]}}, wb_half};
      rv32i_pkg::ld_lhu: load_ext = {16'd0, wb_half};
      default:           load_ext = wb_q.load_word;
    endcase
    case (wb_q.ms.ctrl.wb_sel)
      pipe_pkg::wb_load: wb_data = load_ext;
      pipe_pkg::wb_pc4:  wb_data = wb_q.ms.pc + 32'd4;
      default:           wb_data = wb_q.ms.alu;
    endcase
  end

  // PC and stage registers, frozen as a whole on stall
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc_q  <= RESET_PC;
      id_q  <= '0;
      ex_q  <= '0;
      mem_q <= '0;
      wb_q  <= '0;
    end else if (!stall) begin
      pc_q <= next_pc;
      if (flush) begin
        id_q  <= '0;
        ex_q  <= '0;
        mem_q <= '0;
      end else begin
        id_q.pc     <= pc_q;
        id_q.instr  <= icache_rdata;
        ex_q.pc     <= id_q.pc;
        ex_q.instr  <= id_q.instr;
        ex_q.ctrl   <= id_ctrl;
        ex_q.rs1    <= rs1_val;
        ex_q.rs2    <= rs2_val;
        mem_q.pc    <= ex_q.pc;
        mem_q.instr <= ex_q.instr;
        mem_q.ctrl  <= ex_q.ctrl;
        mem_q.alu   <= alu_result;
        mem_q.rs2   <= ex_q.rs2;
        mem_q.taken <= ex_taken;
      end
      wb_q.ms        <= mem_q;
      wb_q.load_word <= load_data;
    end
  end

endmodule

`default_nettype wire

// ==== hw/rv32i_pipe_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv32i_pipe_top #(
  parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
  input  wire logic        clk,
  input  wire logic        arst_n,
  output logic      [31:0] icache_addr,
  input  wire logic [31:0] icache_rdata,
  output pipe_pkg::dmem_req_t dcache_req,
  input  wire logic        dcache_resp,
  input  wire logic [31:0] dcache_rdata
);

  pipe_pkg::dmem_req_t mem_req;
  logic                stall;
  logic [31:0]         load_data;

  datapath #(
    .RESET_PC (RESET_PC)
  ) datapath_i (
    .clk          (clk),
    .arst_n       (arst_n),
    .icache_addr  (icache_addr),
    .icache_rdata (icache_rdata),
    .mem_req      (mem_req),
    .stall        (stall),
    .load_data    (load_data)
  );

  dmem_fsm dmem_fsm_i (
    .clk          (clk),
    .arst_n       (arst_n),
    .mem_req      (mem_req),
    .dcache_req   (dcache_req),
    .dcache_resp  (dcache_resp),
    .dcache_rdata (dcache_rdata),
    .stall        (stall),
    .load_data    (load_data)
  );

endmodule

`default_nettype wire

// ==== verification/store_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module store_checker (
  input  wire logic                clk,
  input  wire logic                arst_n,
  input  wire pipe_pkg::dmem_req_t dcache_req,
  input  wire logic                dcache_resp,
  output logic                     done,
  output int                       pass_count,
  output int                       fail_count
);

  logic [31:0] exp_addr [64];
  logic [31:0] exp_data [64];
  logic [3:0]  exp_mbe  [64];
  int          n_exp = 0;
  int          idx = 0;
  logic        seen_store = 1'b0;

  initial begin
    pass_count = 0;
    fail_count = 0;
  end

  // Filled by the testbench while it builds the program
  task automatic add_expected(input logic [31:0] addr, input logic [31:0] data,
                              input logic [3:0] mbe);
    exp_addr[n_exp] = addr;
    exp_data[n_exp] = data;
    exp_mbe[n_exp]  = mbe;
    n_exp++;
  endtask

  function automatic logic [31:0] byte_mask(input logic [3:0] mbe);
    return {{8{mbe[3]}}, {8{mbe[2]}}, {8{mbe[1]}}, {8{mbe[0]}}};
  endfunction

  assign done = (n_exp > 0) && (idx == n_exp);

  always @(posedge clk) begin
    logic        bad;
    logic [31:0] mask;
    bad = 1'b0;
    if (!arst_n && (dcache_req.read || dcache_req.write)) begin
      $display("Data port request raised while reset is active at %0t", $time);
      fail_count++;
    end else if (!seen_store && dcache_req.read) begin
      $display("Data read issued before the first store at %0t", $time);
      fail_count++;
    end
    if (arst_n && dcache_req.write && dcache_resp) begin
      seen_store = 1'b1;
      if (idx >= n_exp) begin
        $display("Store seen after the last expected store at %0t", $time);
        fail_count++;
      end else begin
        // Only enabled byte lanes carry store data
        mask = byte_mask(exp_mbe[idx]);
        if (dcache_req.addr !== exp_addr[idx]) begin
          $display("FAIL t=%0t dcache_req.addr exp %h got %h", $time,
                   exp_addr[idx], dcache_req.addr);
          bad = 1'b1;
        end
        if (dcache_req.mbe !== exp_mbe[idx]) begin
          $display("FAIL t=%0t dcache_req.mbe exp %b got %b", $time,
                   exp_mbe[idx], dcache_req.mbe);
          bad = 1'b1;
        end
        if ((dcache_req.wdata & mask) !== (exp_data[idx] & mask)) begin
          $display("FAIL t=%0t dcache_req.wdata exp %h got %h", $time,
                   exp_data[idx] & mask, dcache_req.wdata & mask);
          bad = 1'b1;
        end
        if (bad) begin
          fail_count++;
        end else begin
          $display("PASS store %0d addr %h data %h mbe %b", idx, dcache_req.addr,
                   dcache_req.wdata & mask, dcache_req.mbe);
          pass_count++;
        end
        idx++;
      end
    end
  end

endmodule

`default_nettype wire

// ==== verification/rv32i_pipe_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv32i_pipe_tb;

  localparam int opc_op     = 'h33;
  localparam int opc_op_imm = 'h13;
  localparam int opc_lui    = 'h37;
  localparam int opc_auipc  = 'h17;
  localparam int opc_jal    = 'h6f;
  localparam int opc_jalr   = 'h67;
  localparam int opc_branch = 'h63;
  localparam int opc_load   = 'h03;
  localparam int opc_store  = 'h23;
  localparam logic [31:0] nop = 32'h0000_0013;
  localparam int timeout_cycles = 20000;

  logic                clk;
  logic                arst_n;
  logic [31:0]         icache_addr;
  logic [31:0]         icache_rdata;
  pipe_pkg::dmem_req_t dcache_req;
  logic                dcache_resp;
  logic [31:0]         dcache_rdata;
  logic                done;
  int                  pass_count;
  int                  fail_count;

  logic [31:0] imem [512];
  logic [31:0] dmem [256];
  logic [31:0] prog [$];
  int          st_off;
  int          seed = 32'h3395;

  rv32i_pipe_top #(.RESET_PC(32'h0000_0000)) rv32i_pipe_top_i (
    .clk          (clk),
    .arst_n       (arst_n),
    .icache_addr  (icache_addr),
    .icache_rdata (icache_rdata),
    .dcache_req   (dcache_req),
    .dcache_resp  (dcache_resp),
    .dcache_rdata (dcache_rdata)
  );

  store_checker store_checker_i (
    .clk         (clk),
    .arst_n      (arst_n),
    .dcache_req  (dcache_req),
    .dcache_resp (dcache_resp),
    .done        (done),
    .pass_count  (pass_count),
    .fail_count  (fail_count)
  );

  // Instruction port answers in the same cycle
  assign icache_rdata = imem[icache_addr[10:2]];

  function automatic logic [31:0] r_type(int f7, int rs2, int rs1, int f3, int rd);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], opc_op[6:0]};
  endfunction

  function automatic logic [31:0] i_type(int imm, int rs1, int f3, int rd, int opc);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc[6:0]};
  endfunction

  function automatic logic [31:0] s_type(int imm, int rs2, int rs1, int f3);
    return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], opc_store[6:0]};
  endfunction

  function automatic logic [31:0] b_type(int imm, int rs2, int rs1, int f3);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11],
            opc_branch[6:0]};
  endfunction

  function automatic logic [31:0] u_type(int imm20, int rd, int opc);
    return {imm20[19:0], rd[4:0], opc[6:0]};
  endfunction

  function automatic logic [31:0] j_type(int imm, int rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], opc_jal[6:0]};
  endfunction

  task automatic emit(input logic [31:0] word);
    prog.push_back(word);
  endtask

  // Producer followed by enough slots for its result to reach the register file
  task automatic emit_op(input logic [31:0] word);
    emit(word);
    repeat (3) emit(nop);
  endtask

  task automatic store_word(input int rs, input logic [31:0] exp);
    emit(s_type(st_off, rs, 1, 2));
    store_checker_i.add_expected(32'h300 + st_off, exp, 4'hf);
    st_off += 4;
  endtask

  task automatic check_alu(input logic [31:0] word, input int rd, input logic [31:0] exp);
    emit_op(word);
    store_word(rd, exp);
  endtask

  task automatic check_load(input int f3, input int off, input logic [31:0] exp);
    emit_op(i_type(off, 20, f3, 21, opc_load));
    store_word(21, exp);
  endtask

  // Three stores that must never reach the data port
  task automatic shadow_stores();
    repeat (3) emit(s_type('hf0, 4, 1, 2));
  endtask

  task automatic build_program();
    int link;
    int tgt;
    st_off = 0;
    emit_op(i_type('h300, 0, 0, 1, opc_op_imm));
    emit_op(u_type('h12345, 2, opc_lui));
    emit_op(i_type('h678, 2, 0, 2, opc_op_imm));
    emit_op(i_type(-5, 0, 0, 3, opc_op_imm));
    emit_op(i_type(7, 0, 0, 4, opc_op_imm));
    emit_op(i_type('h200, 0, 0, 20, opc_op_imm));
    check_alu(r_type(0, 4, 2, 0, 5), 5, 32'h1234_567f);
    check_alu(r_type('h20, 3, 4, 0, 6), 6, 32'h0000_000c);
    check_alu(i_type('hf0, 2, 7, 7, opc_op_imm), 7, 32'h0000_0070);
    check_alu(r_type(0, 4, 2, 6, 8), 8, 32'h1234_567f);
    check_alu(r_type(0, 3, 2, 4, 9), 9, 32'hedcb_a983);
    check_alu(r_type(0, 4, 3, 2, 10), 10, 32'h0000_0001);
    check_alu(r_type(0, 4, 3, 3, 11), 11, 32'h0000_0000);
    check_alu(i_type(-4, 3, 2, 12, opc_op_imm), 12, 32'h0000_0001);
    check_alu(i_type(4, 2, 1, 13, opc_op_imm), 13, 32'h2345_6780);
    check_alu(i_type(4, 3, 5, 14, opc_op_imm), 14, 32'h0fff_ffff);
    check_alu(i_type('h401, 3, 5, 15, opc_op_imm), 15, 32'hffff_fffd);
    check_alu(r_type('h20, 4, 2, 5, 16), 16, 32'h0024_68ac);
    check_alu(i_type(-1, 4, 4, 17, opc_op_imm), 17, 32'hffff_fff8);
    check_alu(u_type('habcde, 18, opc_lui), 18, 32'habcd_e000);
    tgt = prog.size() * 4 + 'h1000;
    check_alu(u_type('h1, 19, opc_auipc), 19, tgt);
    // Byte and halfword stores at every offset
    for (int o = 0; o < 4; o++) begin
      emit(s_type(st_off + o, 2, 1, 0));
      store_checker_i.add_expected(32'h300 + st_off, 32'h1234_5678 << (8 * o), 4'b0001 << o);
    end
    st_off += 4;
    for (int o = 0; o < 4; o += 2) begin
      emit(s_type(st_off + o, 2, 1, 1));
      store_checker_i.add_expected(32'h300 + st_off, 32'h1234_5678 << (8 * o), 4'b0011 << o);
    end
    st_off += 4;
    // Word at 0x200 holds f08a7f81
    check_load(0, 0, 32'hffff_ff81);
    check_load(4, 0, 32'h0000_0081);
    check_load(0, 1, 32'h0000_007f);
    check_load(0, 3, 32'hffff_fff0);
    check_load(4, 2, 32'h0000_008a);
    check_load(1, 0, 32'h0000_7f81);
    check_load(1, 2, 32'hffff_f08a);
    check_load(5, 2, 32'h0000_f08a);
    check_load(2, 0, 32'hf08a_7f81);
    // Taken branches jump over their shadow stores
    emit(b_type(16, 4, 4, 0));
    shadow_stores();
    emit(b_type(16, 4, 4, 1));
    store_word(4, 32'h0000_0007);
    repeat (2) emit(nop);
    emit(b_type(16, 4, 3, 4));
    shadow_stores();
    emit(b_type(16, 3, 4, 5));
    shadow_stores();
    emit(b_type(16, 4, 3, 6));
    store_word(3, 32'hffff_fffb);
    repeat (2) emit(nop);
    emit(b_type(16, 4, 3, 7));
    shadow_stores();
    link = prog.size() * 4 + 4;
    emit(j_type(16, 22));
    shadow_stores();
    store_word(22, link);
    // Target has bit 0 set for jalr to clear
    tgt = (prog.size() + 8) * 4;
    emit_op(i_type(tgt, 0, 0, 23, opc_op_imm));
    link = prog.size() * 4 + 4;
    emit(i_type(1, 23, 0, 24, opc_jalr));
    shadow_stores();
    store_word(24, link);
    // Final marker store and a spin loop
    emit(s_type('hfc, 2, 1, 2));
    store_checker_i.add_expected(32'h3fc, 32'h1234_5678, 4'hf);
    emit(j_type(0, 0));
  endtask

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Data memory with a random response delay of 0 to 4 cycles
  initial begin
    int          delay;
    logic [31:0] word;
    dcache_resp  = 1'b0;
    dcache_rdata = '0;
    for (int i = 0; i < 256; i++) begin
      dmem[i] = 32'hc0de_0000 | (i * 4);
    end
    dmem[128] = 32'hf08a_7f81;
    forever begin
      @(posedge clk);
      #1;
      if (dcache_req.read || dcache_req.write) begin
        delay = int'($unsigned($random(seed)) % 32'd5);
        repeat (delay) begin
          @(posedge clk);
          #1;
        end
        word = dmem[dcache_req.addr[9:2]];
        if (dcache_req.write) begin
          for (int b = 0; b < 4; b++) begin
            if (dcache_req.mbe[b]) word[8 * b +: 8] = dcache_req.wdata[8 * b +: 8];
          end
          dmem[dcache_req.addr[9:2]] = word;
        end
        dcache_rdata = word;
        dcache_resp  = 1'b1;
        @(posedge clk);
        #1;
        dcache_resp = 1'b0;
      end
    end
  end

  initial begin
    int cycles;
    arst_n = 1'b0;
    for (int i = 0; i < 512; i++) begin
      imem[i] = nop;
    end
    build_program();
    for (int i = 0; i < prog.size(); i++) begin
      imem[i] = prog[i];
    end
    repeat (10) @(posedge clk);
    #1;
    arst_n = 1'b1;
    cycles = 0;
    while (!done && cycles < timeout_cycles) begin
      @(posedge clk);
      cycles++;
    end
    #1;
    if (!done) begin
      $display("Timeout: the final marker store did not arrive within %0d cycles",
               timeout_cycles);
    end
    $display("Checks: %0d passed, %0d failed", pass_count, fail_count);
    if (done && fail_count == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
hw/rv32i_pkg.sv
hw/pipe_pkg.sv
hw/ctrl_rom.sv
hw/regfile.sv
hw/alu_cmp.sv
hw/dmem_fsm.sv
hw/datapath.sv
hw/rv32i_pipe_top.sv
verification/store_checker.sv
verification/rv32i_pipe_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the pipeline testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f verilog.f --top-module rv32i_pipe_tb -o rv32i_pipe_sim

out=$(./obj_dir/rv32i_pipe_sim)
echo "$out"

if echo "$out" | grep -q "SIMULATION PASSED"; then
  exit 0
else
  exit 1
fi
